// File: Bender.yml
package:
  name: cpu

sources:
  # shared package first, top level last
  - common/cpu_pkg.sv
  - src/pipe_reg.sv
  - src/fwd_ctrl.sv
  - decode/reg_file.sv
  - decode/instr_decode.sv
  - execute/alu.sv
  - src/cpu.sv
  - target: simulation
    files:
      - dv/cpu_props.sv
      - dv/cpu_checker.sv
      - dv/cpu_tb.sv

// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    localparam int xlen = 32;
    localparam int reg_count = 32;
    localparam int imm_w = 12;
    // shift amount comes from the low bits of operand 2
    localparam int shamt_w = 5;

    typedef logic [4:0] reg_sel_t;

    //////////////////////////////
    // instruction fields
    //////////////////////////////
    localparam int op_msb = 31;
    localparam int op_lsb = 27;
    localparam int rd_msb = 26;
    localparam int rd_lsb = 22;
    localparam int rs1_msb = 21;
    localparam int rs1_lsb = 17;
    localparam int rs2_msb = 16;
    localparam int rs2_lsb = 12;
    localparam int imm_msb = 11;
    localparam int imm_lsb = 0;

    // anything outside this list decodes as nop
    typedef enum logic [4:0] {
        op_nop  = 5'd0,
        op_add  = 5'd1,
        op_sub  = 5'd2,
        op_and  = 5'd3,
        op_or   = 5'd4,
        op_xor  = 5'd5,
        op_shl  = 5'd6,
        op_shr  = 5'd7,
        op_addi = 5'd8,
        op_andi = 5'd9,
        op_ori  = 5'd10
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_shl,
        alu_shr
    } alu_op_e;

    // operand source for execute
    typedef enum logic {
        fwd_rf,
        fwd_wb
    } fwd_sel_e;

    //////////////////////////////
    // pipeline payloads
    //////////////////////////////
    typedef struct packed {
        alu_op_e             alu_op;
        logic                imm_sel;
        reg_sel_t            rs1;
        reg_sel_t            rs2;
        reg_sel_t            rd;
        logic                we;
        logic [xlen-1:0]     op1;
        logic [xlen-1:0]     op2;
        logic [xlen-1:0]     imm;
    } de_ex_t;

    typedef struct packed {
        reg_sel_t            rd;
        logic                we;
        logic [xlen-1:0]     result;
    } ex_wb_t;

endpackage

`default_nettype wire

// File: decode/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
    input  logic [cpu_pkg::xlen-1:0]    instr,
    output cpu_pkg::reg_sel_t           rf_rd1_sel,
    output cpu_pkg::reg_sel_t           rf_rd2_sel,
    input  logic [cpu_pkg::xlen-1:0]    rf_rd1_data,
    input  logic [cpu_pkg::xlen-1:0]    rf_rd2_data,
    output cpu_pkg::de_ex_t             payload
);

    //////////////////////////////
    // field split
    //////////////////////////////
    cpu_pkg::opcode_e           opcode;
    cpu_pkg::reg_sel_t          rd;
    cpu_pkg::reg_sel_t          rs1;
    cpu_pkg::reg_sel_t          rs2;
    logic [cpu_pkg::imm_w-1:0]  imm_raw;
    logic [cpu_pkg::xlen-1:0]   imm_ext;

    // control
    cpu_pkg::alu_op_e           alu_op;
    logic                       imm_sel;
    logic                       writes;

    assign opcode  = cpu_pkg::opcode_e'(instr[cpu_pkg::op_msb:cpu_pkg::op_lsb]);
    assign rd      = instr[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
    assign rs1     = instr[cpu_pkg::rs1_msb:cpu_pkg::rs1_lsb];
    assign rs2     = instr[cpu_pkg::rs2_msb:cpu_pkg::rs2_lsb];
    assign imm_raw = instr[cpu_pkg::imm_msb:cpu_pkg::imm_lsb];

    // sign extend
    assign imm_ext = {{(cpu_pkg::xlen - cpu_pkg::imm_w){imm_raw[cpu_pkg::imm_w-1]}}, imm_raw};

    //////////////////////////////
    // opcode map
    //////////////////////////////
    always_comb begin
        alu_op  = cpu_pkg::alu_add;
        imm_sel = 1'b0;
        writes  = 1'b1;
        case (opcode)
            cpu_pkg::op_add:  alu_op = cpu_pkg::alu_add;
            cpu_pkg::op_sub:  alu_op = cpu_pkg::alu_sub;
            cpu_pkg::op_and:  alu_op = cpu_pkg::alu_and;
            cpu_pkg::op_or:   alu_op = cpu_pkg::alu_or;
            cpu_pkg::op_xor:  alu_op = cpu_pkg::alu_xor;
            cpu_pkg::op_shl:  alu_op = cpu_pkg::alu_shl;
            cpu_pkg::op_shr:  alu_op = cpu_pkg::alu_shr;
            cpu_pkg::op_addi: begin
                alu_op  = cpu_pkg::alu_add;
                imm_sel = 1'b1;
            end
            cpu_pkg::op_andi: begin
                alu_op  = cpu_pkg::alu_and;
                imm_sel = 1'b1;
            end
            cpu_pkg::op_ori: begin
                alu_op  = cpu_pkg::alu_or;
                imm_sel = 1'b1;
            end
            // nop and unknown opcodes
            default: writes = 1'b0;
        endcase
    end

    // rf read addresses straight from the fields
    assign rf_rd1_sel = rs1;
    assign rf_rd2_sel = rs2;

    // payload into de/ex, rd 0 never writes
    always_comb begin
        payload.alu_op  = alu_op;
        payload.imm_sel = imm_sel;
        payload.rs1     = rs1;
        payload.rs2     = rs2;
        payload.rd      = rd;
        payload.we      = writes && (rd != '0);
        payload.op1     = rf_rd1_data;
        payload.op2     = rf_rd2_data;
        payload.imm     = imm_ext;
    end

endmodule

`default_nettype wire

// File: decode/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  cpu_pkg::reg_sel_t           rd1_sel,
    input  cpu_pkg::reg_sel_t           rd2_sel,
    output logic [cpu_pkg::xlen-1:0]    rd1_data,
    output logic [cpu_pkg::xlen-1:0]    rd2_data,
    input  logic                        we,
    input  cpu_pkg::reg_sel_t           wr_sel,
    input  logic [cpu_pkg::xlen-1:0]    wr_data
);

    // r0 has no storage
    logic [cpu_pkg::xlen-1:0] regs [1:cpu_pkg::reg_count-1];

    // r0 -> zero, same-cycle write -> bypass, else stored value
    function automatic logic [cpu_pkg::xlen-1:0] read_port(input cpu_pkg::reg_sel_t sel);
        logic [cpu_pkg::xlen-1:0] val;
        if (sel == '0) begin
            val = '0;
        end else if (we && (sel == wr_sel)) begin
            val = wr_data;
        end else begin
            val = regs[sel];
        end
        return val;
    endfunction

    //////////////////////////////
    // write port
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < cpu_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_sel != '0)) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // read ports
    always_comb begin
        rd1_data = read_port(rd1_sel);
        rd2_data = read_port(rd2_sel);
    end

endmodule

`default_nettype wire

// File: dv/cpu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    // instruction side of the dut
    input  logic                        instr_valid,
    input  logic                        exp_write,
    input  cpu_pkg::reg_sel_t           exp_sel,
    input  logic [cpu_pkg::xlen-1:0]    exp_data,
    // writeback side
    input  logic                        wb_valid,
    input  cpu_pkg::reg_sel_t           wb_sel,
    input  logic [cpu_pkg::xlen-1:0]    wb_data,
    output int                          pending,
    output int                          mismatch_count,
    output int                          fail_count
);

    // strobe to writeback, in cycles
    localparam int latency = 2;

    //////////////////////////////
    // expected queue
    //////////////////////////////
    cpu_pkg::reg_sel_t          sel_q [$];
    logic [cpu_pkg::xlen-1:0]   data_q [$];
    int                         sent_q [$];

    int cycle = 0;
    int queued = 0;
    int mismatches = 0;
    int failures = 0;

    assign pending        = queued;
    assign mismatch_count = mismatches;
    assign fail_count     = failures;

    // oldest entry against the strobe
    task automatic check_writeback();
        cpu_pkg::reg_sel_t          want_sel;
        logic [cpu_pkg::xlen-1:0]   want_data;
        int                         sent;
        if ($isunknown(wb_valid)) begin
            $display("wb_valid is unknown in cycle %0d", cycle);
            failures++;
        end else if (wb_valid) begin
            if (sel_q.size() == 0) begin
                $display("writeback in cycle %0d with no writing instruction outstanding", cycle);
                failures++;
            end else begin
                want_sel  = sel_q.pop_front();
                want_data = data_q.pop_front();
                sent      = sent_q.pop_front();
                if (cycle - sent != latency) begin
                    $display("writeback in cycle %0d for instruction sent in cycle %0d, late or early",
                             cycle, sent);
                    failures++;
                end
                if (wb_sel !== want_sel) begin
                    $display("MISMATCH wb_sel: got 0x%h expected 0x%h", wb_sel, want_sel);
                    mismatches++;
                end
                if (wb_data !== want_data) begin
                    $display("MISMATCH wb_data: got 0x%h expected 0x%h", wb_data, want_data);
                    mismatches++;
                end
            end
        end
    endtask

    // entry past its slot never got a strobe
    task automatic drop_overdue();
        while ((sent_q.size() > 0) && (cycle - sent_q[0] > latency)) begin
            $display("no writeback for instruction sent in cycle %0d to register %0d",
                     sent_q[0], sel_q[0]);
            failures++;
            void'(sel_q.pop_front());
            void'(data_q.pop_front());
            void'(sent_q.pop_front());
        end
    endtask

    //////////////////////////////
    // per-edge sampling
    //////////////////////////////
    always @(posedge clk) begin
        if (!rst_n) begin
            // first edge is where the reset takes hold
            if ((cycle > 0) && (wb_valid !== 1'b0)) begin
                $display("wb_valid not low during reset in cycle %0d", cycle);
                failures++;
            end
        end else begin
            check_writeback();
            drop_overdue();
            if (instr_valid && exp_write) begin
                sel_q.push_back(exp_sel);
                data_q.push_back(exp_data);
                sent_q.push_back(cycle);
            end
        end
        queued = sel_q.size();
        cycle++;
    end

endmodule

`default_nettype wire

// File: dv/cpu_golden.hex
// columns: instruction word, destination register (00 = no write expected), value
// fields: op 31:27, rd 26:22, rs1 21:17, rs2 16:12, imm 11:0 sign-extended
40400123 01 00000123  // addi r1, r0, 0x123
40800FFF 02 FFFFFFFF  // addi r2, r0, -1
40C007F0 03 000007F0  // addi r3, r0, 0x7f0
410005A5 04 000005A5  // addi r4, r0, 0x5a5
00000000 00 00000000  // nop
09423000 05 00000913  // add r5, r1, r3
11824000 06 FFFFFB7E  // sub r6, r1, r4
19C44000 07 000005A5  // and r7, r2, r4
22064000 08 000007F5  // or r8, r3, r4
2A464000 09 00000255  // xor r9, r3, r4
42800004 0A 00000004  // addi r10, r0, 4
32C2A000 0B 00001230  // shl r11, r1, r10
3B04A000 0C 0FFFFFFF  // shr r12, r2, r10
4B4400F0 0D 000000F0  // andi r13, r2, 0x0f0
53820800 0E FFFFF923  // ori r14, r1, 0x800
43C20F00 0F 00000023  // addi r15, r1, -256
44000001 10 00000001  // addi r16, r0, 1
0C210000 10 00000002  // add r16, r16, r16
0C210000 10 00000004  // add r16, r16, r16
0C210000 10 00000008  // add r16, r16, r16
44600010 11 00000018  // addi r17, r16, 0x10
14A30000 12 00000010  // sub r18, r17, r16
2CE51000 13 00000008  // xor r19, r18, r17
400207FF 00 00000000  // addi r0, r1, 0x7ff
FD000123 00 00000000  // unknown opcode 31
5D400000 00 00000000  // unknown opcode 11
08022000 00 00000000  // add r0, r1, r2
0D001000 14 00000123  // add r20, r0, r1
25400000 15 00000000  // or r21, r0, r0
00000000 00 00000000  // nop
4580003C 16 0000003C  // addi r22, r0, 0x3c
00000000 00 00000000  // nop
0DED6000 17 00000078  // add r23, r22, r22
362E1000 18 000003C0  // shl r24, r23, r1
3E5D8000 19 FFFFF923  // shr r25, r14, r24
16819000 1A 000006DD  // sub r26, r0, r25

// File: dv/cpu_props.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_props (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  logic              de_we,
    input  logic              wb_valid,
    input  cpu_pkg::reg_sel_t wb_sel
);

    int assert_fails = 0;

    // writing instr gives a strobe exactly two edges later
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (instr_valid && de_we) |-> ##2 wb_valid)
    else begin
        assert_fails++;
        $error("writing instruction without wb_valid two cycles later");
    end

    // no strobe without a writer two edges back
    a_no_stray: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> $past(instr_valid && de_we, 2))
    else begin
        assert_fails++;
        $error("wb_valid without a writing instruction two cycles before");
    end

    // r0 is never written
    a_sel_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (wb_sel != '0))
    else begin
        assert_fails++;
        $error("wb_valid high with wb_sel of zero");
    end

    // quiet while held in reset, after the first reset edge
    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !wb_valid)
    else begin
        assert_fails++;
        $error("wb_valid high during reset");
    end

endmodule

bind cpu cpu_props i_cpu_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .de_we       (de_payload.we),
    .wb_valid    (wb_valid),
    .wb_sel      (wb_sel)
);

`default_nettype wire

// File: dv/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

    //////////////////////////////
    // run constants
    //////////////////////////////
    localparam int clk_period = 8;
    localparam int reset_cycles = 4;
    localparam int entry_count = 36;
    // program runs twice, second pass with random idle gaps
    localparam int pass_count = 2;
    localparam int total_sends = entry_count * pass_count;
    localparam int timeout_cycles = total_sends * 2 + 20;
    localparam logic [31:0] lfsr_seed = 32'h6fa7_48fe;

    logic                       clk;
    logic                       rst_n;
    logic                       instr_valid;
    logic [cpu_pkg::xlen-1:0]   instr;
    logic                       wb_valid;
    cpu_pkg::reg_sel_t          wb_sel;
    logic [cpu_pkg::xlen-1:0]   wb_data;

    // expected result, travels with its instruction
    logic                       exp_write;
    cpu_pkg::reg_sel_t          exp_sel;
    logic [cpu_pkg::xlen-1:0]   exp_data;

    // checker status
    int                         pending;
    int                         mismatch_count;
    int                         check_fails;
    int                         setup_errors;

    logic [31:0]                lfsr;

    // three words per entry: instr, rd (0 = no write), value
    logic [31:0]                golden_mem [0:3*entry_count-1];

    cpu i_cpu (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data)
    );

    cpu_checker i_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .exp_write      (exp_write),
        .exp_sel        (exp_sel),
        .exp_data       (exp_data),
        .wb_valid       (wb_valid),
        .wb_sel         (wb_sel),
        .wb_data        (wb_data),
        .pending        (pending),
        .mismatch_count (mismatch_count),
        .fail_count     (check_fails)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // one bit per entry decides the idle gap
    task automatic drive_entry(input int idx, input bit allow_gap);
        if (allow_gap) begin
            lfsr = lfsr_step(lfsr);
            if (lfsr[0]) begin
                @(posedge clk);
                instr_valid <= 1'b0;
            end
        end
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= golden_mem[3*idx];
        exp_write   <= (golden_mem[3*idx+1] != '0);
        exp_sel     <= golden_mem[3*idx+1][4:0];
        exp_data    <= golden_mem[3*idx+2];
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        exp_write    = 1'b0;
        exp_sel      = '0;
        exp_data     = '0;
        setup_errors = 0;
        lfsr         = lfsr_seed;
        $readmemh("dv/cpu_golden.hex", golden_mem);
        if ($isunknown(golden_mem[3*entry_count-1])) begin
            $display("golden file dv/cpu_golden.hex missing or shorter than %0d entries",
                     entry_count);
            setup_errors++;
        end
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        for (int p = 0; p < pass_count; p++) begin
            for (int i = 0; i < entry_count; i++) begin
                drive_entry(i, p > 0);
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        exp_write   <= 1'b0;
        // checker picks up the last entry, then the pipe drains
        repeat (2) @(negedge clk);
        while (pending != 0) begin
            @(negedge clk);
        end
        // quiet tail, catches stray strobes
        repeat (4) @(negedge clk);
        $display("errors: %0d mismatches, %0d checker failures, %0d assertion failures, %0d setup",
                 mismatch_count, check_fails, i_cpu.i_cpu_props.assert_fails, setup_errors);
        if (mismatch_count + check_fails + i_cpu.i_cpu_props.assert_fails + setup_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_cycles * clk_period);
        $display("watchdog expired after %0d cycles, %0d writebacks still outstanding",
                 timeout_cycles, pending);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: execute/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  cpu_pkg::de_ex_t             op_in,
    input  cpu_pkg::fwd_sel_e           fwd1_sel,
    input  cpu_pkg::fwd_sel_e           fwd2_sel,
    input  logic [cpu_pkg::xlen-1:0]    fwd_data,
    output cpu_pkg::ex_wb_t             result
);

    //////////////////////////////
    // operand select
    //////////////////////////////
    logic [cpu_pkg::xlen-1:0]       src1;
    logic [cpu_pkg::xlen-1:0]       src2_reg;
    logic [cpu_pkg::xlen-1:0]       src2;
    logic [cpu_pkg::shamt_w-1:0]    shamt;
    logic [cpu_pkg::xlen-1:0]       alu_out;

    // forwarding muxes
    always_comb begin
        if (fwd1_sel == cpu_pkg::fwd_wb) begin
            src1 = fwd_data;
        end else begin
            src1 = op_in.op1;
        end
    end

    always_comb begin
        if (fwd2_sel == cpu_pkg::fwd_wb) begin
            src2_reg = fwd_data;
        end else begin
            src2_reg = op_in.op2;
        end
    end

    // immediate wins over rs2 for the i-type ops
    assign src2 = op_in.imm_sel ? op_in.imm : src2_reg;

    // low bits only
    assign shamt = src2[cpu_pkg::shamt_w-1:0];

    //////////////////////////////
    // compute
    //////////////////////////////
    always_comb begin
        case (op_in.alu_op)
            cpu_pkg::alu_add: alu_out = src1 + src2;
            cpu_pkg::alu_sub: alu_out = src1 - src2;
            cpu_pkg::alu_and: alu_out = src1 & src2;
            cpu_pkg::alu_or:  alu_out = src1 | src2;
            cpu_pkg::alu_xor: alu_out = src1 ^ src2;
            cpu_pkg::alu_shl: alu_out = src1 << shamt;
            // logical shift, zero fill
            cpu_pkg::alu_shr: alu_out = src1 >> shamt;
            default:          alu_out = '0;
        endcase
    end

    // rd and we ride along to writeback
    always_comb begin
        result.rd     = op_in.rd;
        result.we     = op_in.we;
        result.result = alu_out;
    end

endmodule

`default_nettype wire

// File: sources.f
common/cpu_pkg.sv
src/pipe_reg.sv
src/fwd_ctrl.sv
decode/reg_file.sv
decode/instr_decode.sv
execute/alu.sv
src/cpu.sv
dv/cpu_props.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

// File: src/cpu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        instr_valid,
    input  logic [cpu_pkg::xlen-1:0]    instr,
    output logic                        wb_valid,
    output cpu_pkg::reg_sel_t           wb_sel,
    output logic [cpu_pkg::xlen-1:0]    wb_data
);

    //////////////////////////////
    // decode stage
    //////////////////////////////
    cpu_pkg::reg_sel_t          rd1_sel;
    cpu_pkg::reg_sel_t          rd2_sel;
    logic [cpu_pkg::xlen-1:0]   rd1_data;
    logic [cpu_pkg::xlen-1:0]   rd2_data;
    cpu_pkg::de_ex_t            de_payload;

    // execute stage
    logic                       ex_valid;
    cpu_pkg::de_ex_t            ex_payload;
    cpu_pkg::fwd_sel_e          fwd1_sel;
    cpu_pkg::fwd_sel_e          fwd2_sel;
    cpu_pkg::ex_wb_t            ex_result;

    // writeback stage
    cpu_pkg::ex_wb_t            wb_payload;

    instr_decode i_decode (
        .instr       (instr),
        .rf_rd1_sel  (rd1_sel),
        .rf_rd2_sel  (rd2_sel),
        .rf_rd1_data (rd1_data),
        .rf_rd2_data (rd2_data),
        .payload     (de_payload)
    );

    // write port fed straight from the ex/wb register
    reg_file i_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd1_sel  (rd1_sel),
        .rd2_sel  (rd2_sel),
        .rd1_data (rd1_data),
        .rd2_data (rd2_data),
        .we       (wb_valid),
        .wr_sel   (wb_payload.rd),
        .wr_data  (wb_payload.result)
    );

    pipe_reg #(.payload_t(cpu_pkg::de_ex_t)) i_de_ex (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (instr_valid),
        .in_data   (de_payload),
        .out_valid (ex_valid),
        .out_data  (ex_payload)
    );

    fwd_ctrl i_fwd_ctrl (
        .ex_rs1   (ex_payload.rs1),
        .ex_rs2   (ex_payload.rs2),
        .wb_valid (wb_valid),
        .wb_we    (wb_payload.we),
        .wb_rd    (wb_payload.rd),
        .fwd1_sel (fwd1_sel),
        .fwd2_sel (fwd2_sel)
    );

    alu i_alu (
        .op_in    (ex_payload),
        .fwd1_sel (fwd1_sel),
        .fwd2_sel (fwd2_sel),
        .fwd_data (wb_payload.result),
        .result   (ex_result)
    );

    // only writing instructions enter writeback
    pipe_reg #(.payload_t(cpu_pkg::ex_wb_t)) i_ex_wb (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (ex_valid & ex_result.we),
        .in_data   (ex_result),
        .out_valid (wb_valid),
        .out_data  (wb_payload)
    );

    assign wb_sel  = wb_payload.rd;
    assign wb_data = wb_payload.result;

endmodule

`default_nettype wire

// File: src/fwd_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fwd_ctrl (
    input  cpu_pkg::reg_sel_t ex_rs1,
    input  cpu_pkg::reg_sel_t ex_rs2,
    input  logic              wb_valid,
    input  logic              wb_we,
    input  cpu_pkg::reg_sel_t wb_rd,
    output cpu_pkg::fwd_sel_e fwd1_sel,
    output cpu_pkg::fwd_sel_e fwd2_sel
);

    //////////////////////////////
    // hazard detect
    //////////////////////////////

    // older instr in writeback has a live result
    logic wb_live;

    // same compare for both operands
    function automatic cpu_pkg::fwd_sel_e pick_src(
        input cpu_pkg::reg_sel_t rs,
        input cpu_pkg::reg_sel_t rd,
        input logic              live
    );
        cpu_pkg::fwd_sel_e sel;
        if (live && (rs == rd)) begin
            sel = cpu_pkg::fwd_wb;
        end else begin
            sel = cpu_pkg::fwd_rf;
        end
        return sel;
    endfunction

    // r0 never forwards, it always reads zero
    assign wb_live = wb_valid && wb_we && (wb_rd != '0);

    // execute read the rf one cycle before this write lands
    assign fwd1_sel = pick_src(ex_rs1, wb_rd, wb_live);
    assign fwd2_sel = pick_src(ex_rs2, wb_rd, wb_live);

endmodule

`default_nettype wire

// File: src/pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // valid tag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload holds while the stage is idle
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire
